// File: src.f
+incdir+src
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_regs.sv
src/uart_tx_serializer.sv
src/uart_rx_deserializer.sv
src/uart_top.sv
verification/uart_tb.sv

// File: Makefile
# Verilator flow for the UART testbench

TOP = uart_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

# Pass only when the simulation prints the pass line
sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: verification/uart_tb.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tb;

    localparam int BIT_CYCLES      = `UART_BIT_CYCLES;
    localparam int DEPTH           = `UART_FIFO_DEPTH;
    localparam int NUM_BYTES       = 10;
    localparam int OVF_BYTES       = DEPTH + 3;
    localparam int CLR_BYTES       = 4;
    localparam int TOTAL_FRAMES    = NUM_BYTES + OVF_BYTES + CLR_BYTES;
    localparam int FRAME_CYCLES    = 10 * BIT_CYCLES;     // Start, eight data, stop
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_FRAMES * FRAME_CYCLES + 2000;

    // Expected status words
    localparam logic [31:0] STATUS_IDLE = (32'd1 << uart_pkg::STA_TX_EMPTY)
                                        | (32'd1 << uart_pkg::STA_RX_EMPTY);
    localparam logic [31:0] STATUS_RX_FULL = (32'd1 << uart_pkg::STA_TX_EMPTY)
                                           | (32'd1 << uart_pkg::STA_RX_FULL)
                                           | (32'(DEPTH) << uart_pkg::STA_RX_WORDS);
    localparam logic [31:0] CTL_RUN_WORD = 32'd1 << uart_pkg::CTL_RUN;

    logic              CLK_IN;
    logic              RST_IN;
    uart_pkg::lb_req_t lb_req;
    uart_pkg::lb_rsp_t lb_rsp;
    logic              serial_line;     // tx_line looped back into rx_line
    integer            seed;
    logic [7:0]        sent_q [$];      // Bytes written to the transmit data address
    logic [7:0]        mon_q [$];       // Bytes decoded from the line

    uart_top uut
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .lb_req  (lb_req),
        .lb_rsp  (lb_rsp),
        .rx_line (serial_line),
        .tx_line (serial_line)
    );

    initial
    begin
        CLK_IN = 1'b0;
        forever #5 CLK_IN = ~CLK_IN;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic bus_write(input uart_pkg::reg_addr_t addr, input logic [31:0] data);
        @(negedge CLK_IN);
        lb_req.adr = addr;
        lb_req.wr  = 1'b1;
        lb_req.din = data;
        @(negedge CLK_IN);
        check("lb_rsp.vld", 32'(lb_rsp.vld), 32'd0);    // No response to a write
        lb_req = '0;
    endtask

    task automatic bus_read(input uart_pkg::reg_addr_t addr, output logic [31:0] data);
        int wait_cnt;
        @(negedge CLK_IN);
        lb_req.adr = addr;
        lb_req.rd  = 1'b1;
        @(negedge CLK_IN);
        lb_req   = '0;
        wait_cnt = 0;
        while (!lb_rsp.vld)
        begin
            if (wait_cnt == 8)
                abort_run("Bus read got no valid response");
            else
            begin
                @(negedge CLK_IN);
                wait_cnt++;
            end
        end
        data = lb_rsp.dout;
        @(negedge CLK_IN);
        check("lb_rsp.vld", 32'(lb_rsp.vld), 32'd0);    // Valid lasts one cycle
    endtask

    function automatic int rx_words(input logic [31:0] st);
        return int'(st[uart_pkg::STA_RX_WORDS +: uart_pkg::STA_WORDS_WIDTH]);
    endfunction

    // Paced by the transmit full flag so no byte is dropped
    task automatic send_byte(input logic [7:0] b);
        logic [31:0] st;
        bus_read(uart_pkg::addr_status, st);
        while (st[uart_pkg::STA_TX_FULL])
            bus_read(uart_pkg::addr_status, st);
        bus_write(uart_pkg::addr_tx_data, {24'd0, b});
        sent_q.push_back(b);
    endtask

    task automatic send_random(input int n);
        for (int i = 0; i < n; i++)
            send_byte(8'($random(seed)));
    endtask

    task automatic wait_rx_words(input int n);
        logic [31:0] st;
        bus_read(uart_pkg::addr_status, st);
        while (rx_words(st) != n)
            bus_read(uart_pkg::addr_status, st);
    endtask

    task automatic wait_monitor(input int n);
        while (mon_q.size() < n)
            @(negedge CLK_IN);
    endtask

    task automatic compare_line_bytes();
        check("monitor byte count", 32'(mon_q.size()), 32'(sent_q.size()));
        for (int i = 0; i < mon_q.size(); i++)
            check("tx_line byte", {24'd0, mon_q[i]}, {24'd0, sent_q[i]});
    endtask

    // Receive FIFO must give back the model bytes in order
    task automatic read_rx_bytes(input int n);
        logic [31:0] d;
        for (int i = 0; i < n; i++)
        begin
            bus_read(uart_pkg::addr_rx_data, d);
            check("rx data", d, {24'd0, sent_q[i]});
        end
    endtask

    task automatic expect_status(input logic [31:0] exp);
        logic [31:0] st;
        bus_read(uart_pkg::addr_status, st);
        check("status", st, exp);
    endtask

    task automatic expect_line_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge CLK_IN);
            check("tx_line", 32'(serial_line), 32'd1);
        end
    endtask

    // Samples near mid-bit from the falling start edge
    task automatic receive_frame(output logic [7:0] data);
        data = '0;
        repeat (BIT_CYCLES / 2) @(negedge CLK_IN);
        if (serial_line !== 1'b0)
            abort_run("Start bit on tx_line ended before mid-bit");
        else
        begin
            for (int i = 0; i < 8; i++)
            begin
                repeat (BIT_CYCLES) @(negedge CLK_IN);
                data[i] = serial_line;    // LSB first
            end
            repeat (BIT_CYCLES) @(negedge CLK_IN);
            if (serial_line !== 1'b1)
                abort_run("Stop bit on tx_line is low");
        end
    endtask

    initial
    begin : line_monitor
        logic [7:0] data;
        wait (RST_IN === 1'b0);
        forever
        begin
            @(negedge serial_line);
            receive_frame(data);
            mon_q.push_back(data);
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLK_IN);
        abort_run($sformatf("Timeout: run did not finish in %0d cycles", WATCHDOG_CYCLES));
    end

    initial
    begin : main_sequence
        logic [31:0] rd_data;
        seed   = 32'h7301_2e5d;
        RST_IN = 1'b1;
        lb_req = '0;
        repeat (2) @(posedge CLK_IN);
        @(negedge CLK_IN);
        RST_IN = 1'b0;

        // Reset state
        bus_read(uart_pkg::addr_ctl, rd_data);
        check("ctl", rd_data, 32'd0);
        expect_status(STATUS_IDLE);
        expect_line_idle(2 * BIT_CYCLES);

        bus_write(uart_pkg::addr_ctl, CTL_RUN_WORD);
        bus_read(uart_pkg::addr_ctl, rd_data);
        check("ctl", rd_data, CTL_RUN_WORD);
        expect_status(STATUS_IDLE);

        // Transmit framing then loopback order
        send_random(NUM_BYTES);
        wait_monitor(NUM_BYTES);
        compare_line_bytes();
        wait_rx_words(NUM_BYTES);
        read_rx_bytes(NUM_BYTES);
        expect_status(STATUS_IDLE);
        sent_q.delete();
        mon_q.delete();

        // Receive overflow drops the last three bytes
        send_random(OVF_BYTES);
        wait_monitor(OVF_BYTES);
        repeat (2 * BIT_CYCLES) @(negedge CLK_IN);    // Last push trails the stop bit
        compare_line_bytes();
        expect_status(STATUS_RX_FULL);
        read_rx_bytes(DEPTH);
        expect_status(STATUS_IDLE);
        sent_q.delete();
        mon_q.delete();

        // Clearing run empties the unread FIFO
        send_random(CLR_BYTES);
        wait_monitor(CLR_BYTES);
        compare_line_bytes();
        wait_rx_words(CLR_BYTES);
        bus_write(uart_pkg::addr_ctl, 32'd0);
        bus_write(uart_pkg::addr_ctl, CTL_RUN_WORD);
        expect_status(STATUS_IDLE);
        expect_line_idle(2 * BIT_CYCLES);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: src/uart_top.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_top
(
    input  logic              CLK_IN,
    input  logic              RST_IN,
    input  uart_pkg::lb_req_t lb_req,
    output uart_pkg::lb_rsp_t lb_rsp,
    input  logic              rx_line,
    output logic              tx_line
);

    uart_pkg::fifo_status_t tx_status;
    uart_pkg::fifo_status_t rx_status;
    logic                   run;
    logic                   fifo_clear;
    logic                   tx_push;
    logic [7:0]             tx_byte;
    logic                   tx_pop;
    logic [7:0]             tx_head;
    logic                   rx_push;
    logic [7:0]             rx_byte;
    logic                   rx_pop;
    logic [7:0]             rx_head;

    assign fifo_clear = ~run;   // Both FIFOs held empty while stopped

    uart_regs regs
    (
        .CLK_IN    (CLK_IN),
        .RST_IN    (RST_IN),
        .lb_req    (lb_req),
        .lb_rsp    (lb_rsp),
        .tx_status (tx_status),
        .rx_status (rx_status),
        .rx_head   (rx_head),
        .run       (run),
        .tx_push   (tx_push),
        .tx_byte   (tx_byte),
        .rx_pop    (rx_pop)
    );

    uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) tx_fifo
    (
        .CLK_IN (CLK_IN),
        .RST_IN (RST_IN),
        .clear  (fifo_clear),
        .push   (tx_push),
        .din    (tx_byte),
        .pop    (tx_pop),
        .head   (tx_head),
        .status (tx_status)
    );

    uart_tx_serializer tx_ser
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .run        (run),
        .fifo_empty (tx_status.empty),
        .fifo_head  (tx_head),
        .pop        (tx_pop),
        .tx_line    (tx_line)
    );

    uart_rx_deserializer rx_des
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .run     (run),
        .rx_line (rx_line),
        .push    (rx_push),
        .rx_byte (rx_byte)
    );

    uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) rx_fifo
    (
        .CLK_IN (CLK_IN),
        .RST_IN (RST_IN),
        .clear  (fifo_clear),
        .push   (rx_push),
        .din    (rx_byte),
        .pop    (rx_pop),
        .head   (rx_head),
        .status (rx_status)
    );

endmodule

// File: src/uart_rx_deserializer.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx_deserializer
(
    input  logic       CLK_IN,
    input  logic       RST_IN,
    input  logic       run,
    input  logic       rx_line,
    output logic       push,
    output logic [7:0] rx_byte
);

    localparam int         BW       = $clog2(`UART_BIT_CYCLES + 1);
    localparam logic [3:0] STOP_BIT = 4'd9;    // Start is 0, data 1 to 8

    uart_pkg::line_state_t state;
    uart_pkg::line_state_t state_nxt;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic                  fall;
    logic [BW-1:0]         beat_cnt;
    logic                  beat;
    logic                  start_ld;
    logic                  bit_inc;
    logic                  shft_nxt;
    logic [3:0]            bit_cnt;
    logic [7:0]            shft;

    assign fall = rx_prev && !rx_sync;
    assign beat = (state == uart_pkg::st_shift) && (beat_cnt == '0);    // Mid-bit sample

    always_comb
    begin
        state_nxt = state;
        start_ld  = 1'b0;
        bit_inc   = 1'b0;
        shft_nxt  = 1'b0;
        push      = 1'b0;
        case (state)
            uart_pkg::st_idle:
            begin
                if (fall)
                begin
                    start_ld  = 1'b1;
                    state_nxt = uart_pkg::st_shift;
                end
            end
            uart_pkg::st_shift:
            begin
                if (beat)
                begin
                    if (bit_cnt == '0)
                    begin
                        // High sample means a glitch, not a start bit
                        if (rx_sync)
                            state_nxt = uart_pkg::st_idle;
                        else
                            bit_inc = 1'b1;
                    end
                    else if (bit_cnt == STOP_BIT)
                    begin
                        push      = rx_sync;    // Bad stop bit drops the frame
                        state_nxt = uart_pkg::st_idle;
                    end
                    else
                    begin
                        shft_nxt = 1'b1;
                        bit_inc  = 1'b1;
                    end
                end
            end
            default: state_nxt = uart_pkg::st_idle;
        endcase
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            state    <= uart_pkg::st_idle;
            beat_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            rx_meta <= rx_line;                 // Two-flop synchronizer
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            state   <= run ? state_nxt : uart_pkg::st_idle;
            if (start_ld)
                beat_cnt <= BW'(`UART_BIT_CYCLES / 2 - 1);    // Half period to mid start bit
            else if (beat)
                beat_cnt <= BW'(`UART_BIT_CYCLES - 1);
            else if (beat_cnt != '0)
                beat_cnt <= beat_cnt - 1'b1;
            if (start_ld)
                bit_cnt <= '0;
            else if (bit_inc)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // LSB arrives first, so fill from the top
    always_ff @(posedge CLK_IN)
    begin
        if (shft_nxt)
            shft <= {rx_sync, shft[7:1]};
    end

    assign rx_byte = shft;

endmodule

// File: src/uart_tx_serializer.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx_serializer
(
    input  logic       CLK_IN,
    input  logic       RST_IN,
    input  logic       run,
    input  logic       fifo_empty,
    input  logic [7:0] fifo_head,
    output logic       pop,
    output logic       tx_line
);

    localparam int BW = $clog2(`UART_BIT_CYCLES + 1);

    uart_pkg::line_state_t state;
    uart_pkg::line_state_t state_nxt;
    logic [BW-1:0]         beat_cnt;
    logic                  beat;            // One cycle per bit period
    logic [8:0]            shft;            // Data byte plus start bit
    logic                  shft_ld;
    logic                  shft_nxt;
    logic [3:0]            bit_cnt;
    logic                  bit_cnt_dec;

    // Beat generator, free running while run is set
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            beat_cnt <= BW'(`UART_BIT_CYCLES - 1);
            beat     <= 1'b0;
        end
        else if (!run)
        begin
            beat_cnt <= BW'(`UART_BIT_CYCLES - 1);
            beat     <= 1'b0;
        end
        else
        begin
            beat     <= (beat_cnt == '0);
            beat_cnt <= (beat_cnt == '0) ? BW'(`UART_BIT_CYCLES - 1) : beat_cnt - 1'b1;
        end
    end

    always_comb
    begin
        state_nxt   = state;
        pop         = 1'b0;
        shft_ld     = 1'b0;
        shft_nxt    = 1'b0;
        bit_cnt_dec = 1'b0;
        case (state)
            uart_pkg::st_idle:
            begin
                if (beat && !fifo_empty)
                begin
                    pop       = 1'b1;
                    shft_ld   = 1'b1;
                    state_nxt = uart_pkg::st_shift;
                end
            end
            uart_pkg::st_shift:
            begin
                if (beat)
                begin
                    if (bit_cnt != '0)
                    begin
                        shft_nxt    = 1'b1;
                        bit_cnt_dec = 1'b1;
                    end
                    else if (!fifo_empty)
                    begin
                        // Stop bit done, next frame follows directly
                        pop     = 1'b1;
                        shft_ld = 1'b1;
                    end
                    else
                        state_nxt = uart_pkg::st_idle;
                end
            end
            default: state_nxt = uart_pkg::st_idle;
        endcase
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            state   <= uart_pkg::st_idle;
            bit_cnt <= '0;
            tx_line <= 1'b1;
        end
        else
        begin
            state   <= run ? state_nxt : uart_pkg::st_idle;
            tx_line <= run ? shft[0] : 1'b1;    // Idle line is high
            if (shft_ld)
                bit_cnt <= 4'd9;                // Eight data bits and stop bit
            else if (bit_cnt_dec)
                bit_cnt <= bit_cnt - 1'b1;
        end
    end

    // Shift register, ones fill in behind the data
    always_ff @(posedge CLK_IN)
    begin
        if (!run)
            shft <= '1;
        else if (shft_ld)
            shft <= {fifo_head, 1'b0};
        else if (shft_nxt)
            shft <= {1'b1, shft[8:1]};
    end

endmodule

// File: src/uart_regs.sv
`timescale 1ns/1ps

module uart_regs
(
    input  logic                   CLK_IN,
    input  logic                   RST_IN,
    input  uart_pkg::lb_req_t      lb_req,
    output uart_pkg::lb_rsp_t      lb_rsp,
    input  uart_pkg::fifo_status_t tx_status,
    input  uart_pkg::fifo_status_t rx_status,
    input  logic [7:0]             rx_head,
    output logic                   run,
    output logic                   tx_push,
    output logic [7:0]             tx_byte,
    output logic                   rx_pop
);

    localparam int STATUS_WIDTH = 16;
    localparam int WW           = uart_pkg::STA_WORDS_WIDTH;

    uart_pkg::lb_req_t       req_q;         // Bus request, one cycle late
    uart_pkg::reg_addr_t     addr;
    logic                    ctl_sel;
    logic                    sta_sel;
    logic                    txd_sel;
    logic                    rxd_sel;
    logic                    ctl_run_q;
    logic [STATUS_WIDTH-1:0] status_word;
    logic [7:0]              rx_last;       // Byte of the last pop

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            req_q <= '0;
        else
            req_q <= lb_req;
    end

    assign addr = uart_pkg::reg_addr_t'(req_q.adr);

    // Address decode
    always_comb
    begin
        ctl_sel = 1'b0;
        sta_sel = 1'b0;
        txd_sel = 1'b0;
        rxd_sel = 1'b0;
        case (addr)
            uart_pkg::addr_ctl:     ctl_sel = 1'b1;
            uart_pkg::addr_status:  sta_sel = 1'b1;
            uart_pkg::addr_tx_data: txd_sel = 1'b1;
            uart_pkg::addr_rx_data: rxd_sel = 1'b1;
            default: ;
        endcase
    end

    // Control register and last received byte
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            ctl_run_q <= 1'b0;
            rx_last   <= '0;
        end
        else
        begin
            if (req_q.wr && ctl_sel)
                ctl_run_q <= req_q.din[uart_pkg::CTL_RUN];
            if (rx_pop)
                rx_last <= rx_head;
        end
    end

    assign run = ctl_run_q;

    always_comb
    begin
        status_word = '0;
        status_word[uart_pkg::STA_TX_EMPTY]       = tx_status.empty;
        status_word[uart_pkg::STA_TX_FULL]        = tx_status.full;
        status_word[uart_pkg::STA_TX_WORDS +: WW] = WW'(tx_status.words);
        status_word[uart_pkg::STA_RX_EMPTY]       = rx_status.empty;
        status_word[uart_pkg::STA_RX_FULL]        = rx_status.full;
        status_word[uart_pkg::STA_RX_WORDS +: WW] = WW'(rx_status.words);
    end

    // Read data, valid in the cycle after the strobe
    always_comb
    begin
        lb_rsp.dout = '0;
        lb_rsp.vld  = req_q.rd;
        if (ctl_sel)
            lb_rsp.dout[uart_pkg::CTL_RUN] = ctl_run_q;
        else if (sta_sel)
            lb_rsp.dout[STATUS_WIDTH-1:0] = status_word;
        else if (rxd_sel)
            lb_rsp.dout[7:0] = rx_status.empty ? rx_last : rx_head;
    end

    assign tx_push = req_q.wr && txd_sel;
    assign tx_byte = req_q.din[7:0];
    assign rx_pop  = req_q.rd && rxd_sel && !rx_status.empty;   // Pops at the end of the cycle

endmodule

// File: src/uart_fifo.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_fifo
#(
    parameter int DEPTH = `UART_FIFO_DEPTH
)
(
    input  logic                   CLK_IN,
    input  logic                   RST_IN,
    input  logic                   clear,
    input  logic                   push,
    input  logic [7:0]             din,
    input  logic                   pop,
    output logic [7:0]             head,
    output uart_pkg::fifo_status_t status
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    logic [7:0]                        mem [DEPTH];
    logic [PTR_WIDTH-1:0]              wr_ptr;
    logic [PTR_WIDTH-1:0]              rd_ptr;
    logic [`UART_FIFO_COUNT_WIDTH-1:0] count_nxt;
    logic                              do_push;
    logic                              do_pop;

    assign do_push = push && !status.full;     // Push while full is dropped
    assign do_pop  = pop && !status.empty;

    always_comb
    begin
        case ({do_push, do_pop})
            2'b10:   count_nxt = status.words + 1'b1;
            2'b01:   count_nxt = status.words - 1'b1;
            default: count_nxt = status.words;
        endcase
    end

    // Pointers and registered status
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            status <= '{empty: 1'b1, full: 1'b0, words: '0};
        end
        else if (clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            status <= '{empty: 1'b1, full: 1'b0, words: '0};
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps, depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            status.words <= count_nxt;
            status.empty <= (count_nxt == '0);
            status.full  <= (count_nxt == DEPTH);
        end
    end

    always_ff @(posedge CLK_IN)
    begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    // Show-ahead output
    assign head = mem[rd_ptr];

endmodule

// File: src/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

    // Local bus request, strobes are single cycle
    typedef struct packed {
        logic [`UART_ADDR_WIDTH-1:0] adr;
        logic                        wr;     // Write strobe
        logic                        rd;     // Read strobe
        logic [`UART_DATA_WIDTH-1:0] din;
    } lb_req_t;

    typedef struct packed {
        logic [`UART_DATA_WIDTH-1:0] dout;
        logic                        vld;    // One cycle after the read strobe
    } lb_rsp_t;

    // FIFO fill state
    typedef struct packed {
        logic                              empty;
        logic                              full;
        logic [`UART_FIFO_COUNT_WIDTH-1:0] words;
    } fifo_status_t;

    typedef enum logic [`UART_ADDR_WIDTH-1:0] {
        addr_ctl     = 4'd0,
        addr_status  = 4'd1,
        addr_tx_data = 4'd2,
        addr_rx_data = 4'd3
    } reg_addr_t;

    // Shared by both serial state machines
    typedef enum logic {
        st_idle,
        st_shift
    } line_state_t;

    // Status register bit positions
    localparam int STA_TX_EMPTY    = 0;
    localparam int STA_TX_FULL     = 1;
    localparam int STA_TX_WORDS    = 2;
    localparam int STA_RX_EMPTY    = 8;
    localparam int STA_RX_FULL     = 9;
    localparam int STA_RX_WORDS    = 10;
    localparam int STA_WORDS_WIDTH = 6;

    localparam int CTL_RUN = 0;     // Control register run bit

endpackage

// File: src/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Serial bit period in clock cycles
`define UART_BIT_CYCLES 16

// Entries per FIFO, power of two
`define UART_FIFO_DEPTH 16

// Fill count, must hold the value UART_FIFO_DEPTH
`define UART_FIFO_COUNT_WIDTH 5

// Local bus widths
`define UART_ADDR_WIDTH 4
`define UART_DATA_WIDTH 32

`endif
